//--- rtl/shared_bus_pkg.sv
package shared_bus_pkg;

    localparam int num_devices = 8;
    localparam int bus_width   = 32;

    // Control word as seen on ctrl_in and ctrl_out
    typedef struct packed {
        logic [2:0] reserved;
        logic [2:0] burst;
        logic       we;
        logic       wait_flag;
    } ctrl_word_t;

    typedef logic [bus_width-1:0]   bus_word_t;
    typedef logic [num_devices-1:0] dev_mask_t;

    // One 16 MB window per device, placed at multiples of 256 MB
    localparam bus_word_t region_base [num_devices] = '{
        32'h0000_0000,
        32'h1000_0000,
        32'h2000_0000,
        32'h3000_0000,
        32'h4000_0000,
        32'h5000_0000,
        32'h6000_0000,
        32'h7000_0000
    };

    // Bits kept as the physical address inside a window
    localparam bus_word_t region_mask [num_devices] = '{default: 32'h00FF_FFFF};

    // Transaction sequence
    typedef enum logic [2:0] {
        st_idle,
        st_grant,
        st_addr,
        st_target_ack,
        st_data,
        st_release
    } bus_state_t;

endpackage

//--- rtl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import shared_bus_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      en,
    input  dev_mask_t req,
    output dev_mask_t grant
);

    dev_mask_t pick;

    // Lowest set bit of req or zero when nobody requests
    always_comb begin
        pick = req & (~req + dev_mask_t'(1));
    end

    // Grant only moves while enabled, so it stays put for a whole transaction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            grant <= '0;
        end else if (en) begin
            grant <= pick;
        end
    end

    // A freshly loaded grant must come from a device that was requesting
    assert property (@(posedge clk) disable iff (!arst_n)
        en |=> (grant & ~$past(req)) == '0)
        else $error("bus_arbiter: grant given to a device without req");

endmodule

//--- rtl/address_translator.sv
`timescale 1ns/1ps

module address_translator import shared_bus_pkg::*; (
    input  bus_word_t vaddr,
    output dev_mask_t target,
    output bus_word_t paddr
);

    // Walk from the top down so the lowest matching index is the last one written
    always_comb begin
        target = '0;
        paddr  = '0;
        for (int i = num_devices - 1; i >= 0; i--) begin
            if ((vaddr & ~region_mask[i]) == region_base[i]) begin
                target = dev_mask_t'(1) << i;
                // Base bits dropped, offset within the window kept
                paddr  = vaddr & region_mask[i];
            end
        end
    end

    // Overlapping windows must still yield a single target
    always_comb begin
        assert final ($onehot0(target))
            else $error("address_translator: several targets for one address");
    end

endmodule

//--- rtl/onehot_mux.sv
`timescale 1ns/1ps

module onehot_mux import shared_bus_pkg::*; #(
    parameter type payload_t = bus_word_t
) (
    input  dev_mask_t                      sel,
    input  payload_t [num_devices-1:0]     in,
    output payload_t                       out
);

    // AND-OR selection, zero when no bit is set
    always_comb begin
        out = '0;
        for (int i = 0; i < num_devices; i++) begin
            if (sel[i]) begin
                out = out | in[i];
            end
        end
    end

    // Two selected sources would be ORed into garbage
    always_comb begin
        assert final ($onehot0(sel))
            else $error("onehot_mux: select has more than one bit set");
    end

endmodule

//--- rtl/bus_output_stage.sv
`timescale 1ns/1ps

module bus_output_stage import shared_bus_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       use_paddr,
    input  logic       hold,
    input  logic       force_ctrl,
    input  bus_word_t  sel_word,
    input  bus_word_t  paddr,
    input  ctrl_word_t sel_ctrl,
    input  logic       xfer_we,
    input  logic [2:0] xfer_burst,
    output bus_word_t  bus_out,
    output ctrl_word_t ctrl_out
);

    // Last cycle's bus value, replayed while the target is notified
    bus_word_t held_word;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            held_word <= '0;
        end else begin
            held_word <= bus_out;
        end
    end

    always_comb begin
        if (hold) begin
            bus_out = held_word;
        end else if (use_paddr) begin
            bus_out = paddr;
        end else begin
            bus_out = sel_word;
        end
    end

    // Target notice word: wait set, transfer direction and burst from the master
    always_comb begin
        ctrl_out = sel_ctrl;
        if (force_ctrl) begin
            ctrl_out.reserved  = '0;
            ctrl_out.burst     = xfer_burst;
            ctrl_out.we        = xfer_we;
            ctrl_out.wait_flag = 1'b1;
        end
    end

endmodule

//--- rtl/bus_controller.sv
`timescale 1ns/1ps

module bus_controller import shared_bus_pkg::*; (
    input  logic                         clk,
    input  logic                         arst_n,
    input  dev_mask_t                    req,
    input  ctrl_word_t [num_devices-1:0] ctrl_in,
    input  bus_word_t  [num_devices-1:0] bus_in,
    output dev_mask_t                    ack,
    output ctrl_word_t                   ctrl_out,
    output bus_word_t                    bus_out
);

    bus_state_t state_q;
    bus_state_t state_d;

    dev_mask_t  grant;
    dev_mask_t  target_hit;
    dev_mask_t  target_q;
    dev_mask_t  bus_sel;
    bus_word_t  bus_word_sel;
    bus_word_t  paddr;
    ctrl_word_t ctrl_sel;

    logic       arb_en;
    logic       use_paddr;
    logic       hold;
    logic       force_ctrl;
    logic       xfer_we;
    logic [2:0] xfer_burst;

    bus_arbiter i_arbiter (
        .clk    (clk),
        .arst_n (arst_n),
        .en     (arb_en),
        .req    (req),
        .grant  (grant)
    );

    // Master's word, or the target's during a read data phase
    onehot_mux #(.payload_t(bus_word_t)) i_bus_mux (
        .sel (bus_sel),
        .in  (bus_in),
        .out (bus_word_sel)
    );

    onehot_mux #(.payload_t(ctrl_word_t)) i_ctrl_mux (
        .sel (ack),
        .in  (ctrl_in),
        .out (ctrl_sel)
    );

    address_translator i_translator (
        .vaddr  (bus_word_sel),
        .target (target_hit),
        .paddr  (paddr)
    );

    bus_output_stage i_output_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .use_paddr  (use_paddr),
        .hold       (hold),
        .force_ctrl (force_ctrl),
        .sel_word   (bus_word_sel),
        .paddr      (paddr),
        .sel_ctrl   (ctrl_sel),
        .xfer_we    (xfer_we),
        .xfer_burst (xfer_burst),
        .bus_out    (bus_out),
        .ctrl_out   (ctrl_out)
    );

    // Sequencing and strobes
    always_comb begin
        state_d    = state_q;
        ack        = '0;
        bus_sel    = grant;
        arb_en     = 1'b0;
        use_paddr  = 1'b0;
        hold       = 1'b0;
        force_ctrl = 1'b0;
        unique case (state_q)
            st_idle: begin
                arb_en = 1'b1;
                if (req != '0) begin
                    state_d = st_grant;
                end
            end
            st_grant: begin
                ack     = grant;
                state_d = st_addr;
            end
            st_addr: begin
                ack       = grant;
                use_paddr = 1'b1;
                // Miss ends the transaction without touching any target
                state_d   = (target_hit == '0) ? st_release : st_target_ack;
            end
            st_target_ack: begin
                ack        = target_q;
                hold       = 1'b1;
                force_ctrl = 1'b1;
                state_d    = st_data;
            end
            st_data: begin
                ack     = target_q;
                bus_sel = xfer_we ? grant : target_q;
                if ((req & grant) == '0) begin
                    state_d = st_release;
                end
            end
            st_release: begin
                arb_en  = 1'b1;
                state_d = (req != '0) ? st_grant : st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= st_idle;
            target_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == st_addr) begin
                target_q <= target_hit;
            end else if (state_q == st_release) begin
                target_q <= '0;
            end
        end
    end

    // Transfer attributes, taken from the master's own control word
    always_ff @(posedge clk) begin
        if (state_q == st_grant) begin
            xfer_burst <= ctrl_sel.burst;
        end
        if (state_q == st_addr) begin
            xfer_we <= ctrl_sel.we;
        end
    end

    // Grant and target come from different blocks, but only one may be acked
    assert property (@(posedge clk) disable iff (!arst_n) $onehot0(ack))
        else $error("bus_controller: ack has more than one bit set");

endmodule

//--- verif/bus_controller_tb.sv
`timescale 1ns/1ps

module bus_controller_tb import shared_bus_pkg::*; ();

    logic                         clk;
    logic                         arst_n;
    dev_mask_t                    req;
    ctrl_word_t [num_devices-1:0] ctrl_in;
    bus_word_t  [num_devices-1:0] bus_in;
    dev_mask_t                    ack;
    ctrl_word_t                   ctrl_out;
    bus_word_t                    bus_out;

    // Reference sequence rebuilt from req and the device model
    bus_state_t ref_state;
    dev_mask_t  ref_grant;
    dev_mask_t  ref_target;
    bus_word_t  ref_paddr;
    logic       ref_we;
    logic [2:0] ref_burst;

    dev_mask_t  exp_ack;
    bus_word_t  exp_bus;
    ctrl_word_t exp_ctrl;
    logic       check_bus;
    logic       check_ctrl;
    int         mst_idx;
    int         tgt_idx;

    int     errors   = 0;
    int     timeouts = 0;
    integer seed     = 32'hd84dd8c1;

    bus_controller i_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (req),
        .ctrl_in  (ctrl_in),
        .bus_in   (bus_in),
        .ack      (ack),
        .ctrl_out (ctrl_out),
        .bus_out  (bus_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic dev_mask_t lowest_requester(dev_mask_t r);
        dev_mask_t g;
        g = '0;
        for (int i = 0; i < num_devices; i++) begin
            if (r[i] && g == '0) begin
                g = dev_mask_t'(1) << i;
            end
        end
        return g;
    endfunction

    function automatic int index_of(dev_mask_t mask);
        int idx;
        idx = 0;
        for (int i = 0; i < num_devices; i++) begin
            if (mask[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // 16 MB windows at n * 256 MB, below 2 GB only
    function automatic dev_mask_t region_of(bus_word_t addr);
        dev_mask_t hit;
        hit = '0;
        if (addr[31] == 1'b0 && addr[27:24] == 4'h0) begin
            hit = dev_mask_t'(1) << addr[30:28];
        end
        return hit;
    endfunction

    function automatic bus_word_t phys_addr(bus_word_t addr);
        return {8'h00, addr[23:0]};
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ref_state  <= st_idle;
            ref_grant  <= '0;
            ref_target <= '0;
            ref_paddr  <= '0;
            ref_we     <= 1'b0;
            ref_burst  <= '0;
        end else begin
            case (ref_state)
                st_idle: begin
                    if (req != '0) begin
                        ref_grant <= lowest_requester(req);
                        ref_state <= st_grant;
                    end
                end
                st_grant: begin
                    ref_burst <= ctrl_in[mst_idx].burst;
                    ref_state <= st_addr;
                end
                st_addr: begin
                    ref_we     <= ctrl_in[mst_idx].we;
                    ref_target <= region_of(bus_in[mst_idx]);
                    ref_paddr  <= phys_addr(bus_in[mst_idx]);
                    ref_state  <= (region_of(bus_in[mst_idx]) == '0) ? st_release : st_target_ack;
                end
                st_target_ack: begin
                    ref_state <= st_data;
                end
                st_data: begin
                    if (!req[mst_idx]) begin
                        ref_state <= st_release;
                    end
                end
                default: begin
                    ref_target <= '0;
                    ref_grant  <= lowest_requester(req);
                    ref_state  <= (req != '0) ? st_grant : st_idle;
                end
            endcase
        end
    end

    always_comb begin
        mst_idx    = index_of(ref_grant);
        tgt_idx    = index_of(ref_target);
        exp_ack    = '0;
        exp_bus    = '0;
        exp_ctrl   = '0;
        check_bus  = 1'b0;
        check_ctrl = 1'b0;
        case (ref_state)
            st_grant: begin
                exp_ack = ref_grant;
            end
            st_addr: begin
                exp_ack   = ref_grant;
                // Physical address exists only for a hit
                check_bus = (region_of(bus_in[mst_idx]) != '0);
                exp_bus   = phys_addr(bus_in[mst_idx]);
            end
            st_target_ack: begin
                exp_ack    = ref_target;
                check_bus  = 1'b1;
                exp_bus    = ref_paddr;
                check_ctrl = 1'b1;
                exp_ctrl   = '{reserved: 3'b000, burst: ref_burst, we: ref_we, wait_flag: 1'b1};
            end
            st_data: begin
                exp_ack    = ref_target;
                check_bus  = 1'b1;
                exp_bus    = ref_we ? bus_in[mst_idx] : bus_in[tgt_idx];
                check_ctrl = 1'b1;
                exp_ctrl   = ctrl_in[tgt_idx];
            end
            default: begin
            end
        endcase
    end

    // Sampled mid-cycle away from the drive edge
    assert property (@(negedge clk) ack == exp_ack)
        else begin
            errors++;
            $display("CHECK FAILED %0t: ack %b in %s, expected %b",
                     $time, ack, ref_state.name(), exp_ack);
        end

    assert property (@(negedge clk) check_bus |-> bus_out == exp_bus)
        else begin
            errors++;
            $display("CHECK FAILED %0t: bus_out %h in %s, expected %h",
                     $time, bus_out, ref_state.name(), exp_bus);
        end

    assert property (@(negedge clk) check_ctrl |-> ctrl_out == exp_ctrl)
        else begin
            errors++;
            $display("CHECK FAILED %0t: ctrl_out %h in %s, expected %h",
                     $time, ctrl_out, ref_state.name(), exp_ctrl);
        end

    task automatic load_master(input int m, input bus_word_t addr, input logic we,
                               input logic [2:0] burst);
        bus_in[m]  = addr;
        ctrl_in[m] = '{reserved: 3'b101, burst: burst, we: we, wait_flag: 1'b0};
    endtask

    task automatic wait_for_state(input bus_state_t st, input int limit);
        int n;
        n = 0;
        while (ref_state != st && n < limit) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (ref_state != st) begin
            timeouts++;
            $display("Timeout at %0t: state %s not reached within %0d cycles",
                     $time, st.name(), limit);
        end
    endtask

    // Fresh write data, read data and target control every cycle
    task automatic run_data(input int m, input int t, input int cycles);
        logic [31:0] rnd;
        repeat (cycles) begin
            rnd        = $random(seed);
            bus_in[m]  = rnd;
            rnd        = $random(seed);
            bus_in[t]  = rnd;
            ctrl_in[t] = ctrl_word_t'(rnd[7:0]);
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        logic [31:0] rnd;
        bus_word_t   addr;
        int          mst;
        req     = '0;
        ctrl_in = '0;
        bus_in  = '0;
        arst_n  = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        repeat (3) @(posedge clk);
        #2;

        // Write, read and miss from three masters requesting together
        load_master(2, 32'h4012_3458, 1'b1, 3'd3);
        load_master(5, 32'h10AB_CDEF, 1'b0, 3'd6);
        load_master(6, 32'h0100_0000, 1'b1, 3'd1);
        req = 8'b0110_0100;
        wait_for_state(st_target_ack, 10);
        run_data(2, 4, 5);
        req[2] = 1'b0;
        wait_for_state(st_release, 10);
        wait_for_state(st_target_ack, 10);
        run_data(5, 1, 4);
        req[5] = 1'b0;
        wait_for_state(st_release, 10);
        wait_for_state(st_addr, 10);
        req[6] = 1'b0;
        wait_for_state(st_idle, 10);

        // Single masters with random windows where every third address misses
        for (int k = 0; k < 6; k++) begin
            rnd  = $random(seed);
            mst  = int'(rnd[2:0]);
            addr = {1'b0, rnd[5:3], 4'h0, rnd[31:8]};
            if (k % 3 == 2) begin
                addr[25] = 1'b1;
            end
            load_master(mst, addr, rnd[6], rnd[9:7]);
            req = dev_mask_t'(1) << mst;
            wait_for_state(st_addr, 10);
            if (k % 3 != 2) begin
                wait_for_state(st_target_ack, 10);
                run_data(mst, int'(addr[30:28]), 4);
            end
            req = '0;
            wait_for_state(st_idle, 10);
        end

        repeat (2) @(posedge clk);
        $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- shared_bus.f
rtl/shared_bus_pkg.sv
rtl/bus_arbiter.sv
rtl/address_translator.sv
rtl/onehot_mux.sv
rtl/bus_output_stage.sv
rtl/bus_controller.sv
verif/bus_controller_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= bus_controller_tb
DUT_TOP   ?= bus_controller
FILELIST  ?= shared_bus.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINTFLAGS) $(filter rtl/%,$(shell cat $(FILELIST))) --top-module $(DUT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
